//--- compile.f
+incdir+testbench
rtl/mmg_pkg.sv
rtl/rd_stamp_fifo.sv
rtl/mm_protector.sv
rtl/apb_mm_bridge.sv
rtl/mm_resp_merge.sv
rtl/mm_guard_top.sv
testbench/tb_mm_guard.sv

//--- rtl/apb_mm_bridge.sv
`timescale 1ns/10ps

module apb_mm_bridge import mmg_pkg::*; (
    input  logic              rst,
    input  logic              clk,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  apb_addr_u         paddr,
    input  logic [MM_DW-1:0]  pwdata,
    output logic              pready,
    output logic [MM_DW-1:0]  prdata,
    output logic              pslverr,
    output mm_req_t           req,
    output logic [PORT_N-1:0] port_sel,    // One-hot, held for the whole transfer
    input  mm_rsp_t           up_rsp,
    input  logic              xfer_fault,
    input  logic [MM_DW-1:0]  status,
    output logic [MM_DW-1:0]  status_clr   // Write-one-to-clear mask, one cycle
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;  // Request out, waiting on busy
    localparam logic [1:0] ST_WAIT  = 2'd2;  // Write ends here, read waits for rval

    logic [1:0]       state;
    logic             wr_q;
    logic [MM_AW-1:0] addr_q;
    logic [MM_DW-1:0] wdat_q;
    logic             setup_win;
    logic             stat_acc;
    logic             issue;
    logic             done;

    // Window transfers are captured in the setup phase
    assign setup_win = (state == ST_IDLE) & psel & ~penable & ~paddr.stat.sel;
    // Status register answers in the first access cycle
    assign stat_acc  = (state == ST_IDLE) & psel & penable & paddr.stat.sel;
    assign issue     = (state == ST_ISSUE);
    assign done      = (state == ST_WAIT) & (wr_q | up_rsp.rval);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= ST_IDLE;
            wr_q     <= 1'b0;
            port_sel <= '0;
        end else begin
            case (state)
                ST_IDLE: if (setup_win) begin
                    state    <= ST_ISSUE;
                    wr_q     <= pwrite;
                    port_sel <= PORT_N'(1) << paddr.win.port;
                end
                ST_ISSUE: if (~up_rsp.busy) state <= ST_WAIT;   // Accepted
                ST_WAIT: if (done) begin
                    state    <= ST_IDLE;
                    port_sel <= '0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge rst) begin
        if (setup_win) begin
            addr_q <= paddr.win.offset;
            wdat_q <= pwdata;
        end
    end

    assign req = '{addr: addr_q, wreq: issue & wr_q, wdat: wdat_q, rreq: issue & ~wr_q};

    assign pready     = stat_acc | done;
    assign prdata     = stat_acc ? status : up_rsp.rdat;
    assign pslverr    = done & xfer_fault;   // Timeout seen on this transfer
    assign status_clr = (stat_acc & pwrite) ? pwdata : '0;

endmodule

//--- rtl/mm_guard_top.sv
`timescale 1ns/10ps

module mm_guard_top import mmg_pkg::*; #(
    parameter int NPORTS      = 2,
    parameter int MAXPENDRD   = 4,
    parameter int BUSYTIMEOUT = 8,
    parameter int RVALTIMEOUT = 8
) (
    input  logic             rst,
    input  logic             clk,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  apb_addr_u        paddr,
    input  logic [MM_DW-1:0] pwdata,
    output logic             pready,
    output logic [MM_DW-1:0] prdata,
    output logic             pslverr,
    output mm_req_t          m_req [NPORTS],   // To the slaves
    input  mm_rsp_t          m_rsp [NPORTS],
    output logic             irq
);
    mm_req_t           bus_req;
    logic [PORT_N-1:0] port_sel;
    mm_rsp_t           up_rsp;
    logic              xfer_fault;
    logic [MM_DW-1:0]  status;
    logic [MM_DW-1:0]  status_clr;
    mm_rsp_t           port_rsp [NPORTS];
    fault_t            port_fault [NPORTS];

    apb_mm_bridge u_bridge (
        .rst        (rst),
        .clk        (clk),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .req        (bus_req),
        .port_sel   (port_sel),
        .up_rsp     (up_rsp),
        .xfer_fault (xfer_fault),
        .status     (status),
        .status_clr (status_clr)
    );

    for (genvar i = 0; i < NPORTS; i++) begin : g_port
        mm_protector #(
            .MAXPENDRD   (MAXPENDRD),
            .BUSYTIMEOUT (BUSYTIMEOUT),
            .RVALTIMEOUT (RVALTIMEOUT)
        ) u_prot (
            .rst   (rst),
            .clk   (clk),
            .s_req (port_sel[i] ? bus_req : mm_req_t'('0)),   // Unselected ports idle
            .s_rsp (port_rsp[i]),
            .m_req (m_req[i]),
            .m_rsp (m_rsp[i]),
            .fault (port_fault[i])
        );
    end

    mm_resp_merge #(
        .NPORTS (NPORTS)
    ) u_merge (
        .rst        (rst),
        .clk        (clk),
        .port_sel   (port_sel[NPORTS-1:0]),
        .rsp_in     (port_rsp),
        .fault_in   (port_fault),
        .status_clr (status_clr),
        .up_rsp     (up_rsp),
        .xfer_fault (xfer_fault),
        .status     (status),
        .irq        (irq)
    );

endmodule

//--- rtl/mm_protector.sv
`timescale 1ns/10ps

module mm_protector import mmg_pkg::*; #(
    parameter int MAXPENDRD   = 4,   // Reads outstanding toward the slave
    parameter int BUSYTIMEOUT = 8,   // Stall cycles before busy is overridden
    parameter int RVALTIMEOUT = 8    // Cycles a read may stay unanswered
) (
    input  logic    rst,
    input  logic    clk,
    input  mm_req_t s_req,   // From the bridge
    output mm_rsp_t s_rsp,
    output mm_req_t m_req,   // To the untrusted slave
    input  mm_rsp_t m_rsp,
    output fault_t  fault
);
    localparam int BUSYCW = $clog2(BUSYTIMEOUT + 1);
    // Wide enough that an entry can't alias before it is forced out
    localparam int RVALCW = $clog2(RVALTIMEOUT + 2) + 1;
    localparam logic [RVALCW-1:0] RVAL_AGE = RVALCW'(RVALTIMEOUT + 1);

    logic [BUSYCW-1:0] busy_cnt;
    logic              stalled;
    logic              busy_last;
    logic              busy_pass;     // Low for one cycle after a timeout
    logic              up_busy;
    logic [RVALCW-1:0] stamp_cnt;
    logic [RVALCW-1:0] head_stamp;
    logic              fifo_push;
    logic              fifo_pop;
    logic              fifo_empty;
    logic              fifo_full;
    logic              forced_rval;
    logic [MM_DW-1:0]  rdat_q;
    logic              rval_q;
    fault_t            fault_q;

    // Request held against slave busy
    assign stalled   = (m_req.wreq | m_req.rreq) & m_rsp.busy;
    assign busy_last = stalled & (busy_cnt == BUSYCW'(BUSYTIMEOUT - 1));

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            busy_cnt <= '0;
        end else if (busy_last | ~stalled) begin
            busy_cnt <= '0;
        end else begin
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    // Resets to pass; drops once the stall count runs out
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            busy_pass <= 1'b1;
        end else begin
            busy_pass <= ~busy_last;
        end
    end

    // Free-running time base for read stamps
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            stamp_cnt <= '0;
        end else begin
            stamp_cnt <= stamp_cnt + 1'b1;
        end
    end

    assign up_busy   = (m_rsp.busy & busy_pass) | fifo_full;
    assign fifo_push = s_req.rreq & ~up_busy;          // Read accepted upstream
    assign fifo_pop  = (forced_rval | m_rsp.rval) & ~fifo_empty;

    rd_stamp_fifo #(
        .DEPTH (MAXPENDRD),
        .WIDTH (RVALCW)
    ) u_stamp_fifo (
        .rst   (rst),
        .clk   (clk),
        .push  (fifo_push),
        .din   (stamp_cnt),
        .pop   (fifo_pop),
        .dout  (head_stamp),
        .empty (fifo_empty),
        .full  (fifo_full)
    );

    // Oldest read has aged out
    assign forced_rval = ~fifo_empty & ((stamp_cnt - head_stamp) == RVAL_AGE);

    // Read data one cycle behind the slave
    always_ff @(posedge rst) begin
        rdat_q <= m_rsp.rval ? m_rsp.rdat : ERR_RDAT;
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rval_q  <= 1'b0;
            fault_q <= '0;
        end else begin
            rval_q               <= fifo_pop;   // Odd rvals are dropped here
            fault_q.busy_timeout <= stalled & ~busy_pass;
            fault_q.rval_timeout <= forced_rval & ~m_rsp.rval;
            fault_q.rval_is_odd  <= m_rsp.rval & fifo_empty;
        end
    end

    // Write path passes straight through, masked while the FIFO is full
    assign m_req = '{addr: s_req.addr,
                     wreq: s_req.wreq & ~fifo_full,
                     wdat: s_req.wdat,
                     rreq: s_req.rreq & ~fifo_full};

    assign s_rsp = '{rdat: rdat_q, rval: rval_q, busy: up_busy};
    assign fault = fault_q;

endmodule

//--- rtl/mm_resp_merge.sv
`timescale 1ns/10ps

module mm_resp_merge import mmg_pkg::*; #(
    parameter int NPORTS = 2
) (
    input  logic              rst,
    input  logic              clk,
    input  logic [NPORTS-1:0] port_sel,
    input  mm_rsp_t           rsp_in [NPORTS],
    input  fault_t            fault_in [NPORTS],
    input  logic [MM_DW-1:0]  status_clr,
    output mm_rsp_t           up_rsp,
    output logic              xfer_fault,
    output logic [MM_DW-1:0]  status,
    output logic              irq
);
    localparam int SW = 3 * NPORTS;   // Three sticky bits per port

    logic [SW-1:0] sticky;
    logic [SW-1:0] pulse;
    logic          cur_fault;
    logic          fault_q;

    always_comb begin
        up_rsp    = '0;    // Nothing selected: idle response
        cur_fault = 1'b0;
        for (int i = 0; i < NPORTS; i++) begin
            pulse[3*i +: 3] = fault_in[i];
            if (port_sel[i]) begin
                up_rsp    = rsp_in[i];
                cur_fault = fault_in[i].busy_timeout | fault_in[i].rval_timeout;
            end
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            fault_q <= 1'b0;
            sticky  <= '0;
        end else begin
            // Held while a transfer is open, cleared between transfers
            fault_q <= (|port_sel) & (fault_q | cur_fault);
            sticky  <= (sticky & ~status_clr[SW-1:0]) | pulse;   // New fault beats clear
        end
    end

    // Current pulse counts too, so a fault in the last cycle is not missed
    assign xfer_fault = fault_q | cur_fault;
    assign status     = MM_DW'(sticky);
    assign irq        = |sticky;

endmodule

//--- rtl/mmg_pkg.sv
package mmg_pkg;

    // Bus widths, fixed here so the structs below have fixed widths
    localparam int MM_AW  = 8;            // Slave offset width
    localparam int MM_DW  = 32;           // Data width
    localparam int PORT_W = 3;            // Port index field
    localparam int PORT_N = 2 ** PORT_W;  // Max number of ports
    localparam int APB_AW = 1 + PORT_W + MM_AW;

    // Returned in place of a read that never came back
    localparam logic [MM_DW-1:0] ERR_RDAT = '1;

    // Window view: select bit low, then port and offset
    typedef struct packed {
        logic              sel;     // 0 selects a slave window
        logic [PORT_W-1:0] port;
        logic [MM_AW-1:0]  offset;
    } apb_win_t;

    // Status view: select bit high, rest reserved
    typedef struct packed {
        logic              sel;     // 1 selects the fault status register
        logic [APB_AW-2:0] rsvd;
    } apb_stat_t;

    // One APB address word read both ways
    typedef union packed {
        apb_win_t  win;
        apb_stat_t stat;
    } apb_addr_u;

    // MemoryMapped request toward a slave
    typedef struct packed {
        logic [MM_AW-1:0] addr;
        logic             wreq;
        logic [MM_DW-1:0] wdat;
        logic             rreq;
    } mm_req_t;

    // MemoryMapped response from a slave
    typedef struct packed {
        logic [MM_DW-1:0] rdat;
        logic             rval;
        logic             busy;
    } mm_rsp_t;

    // One-cycle fault pulses, also the per-port status bit order
    typedef struct packed {
        logic busy_timeout;  // Bit 2 of a port's status field
        logic rval_timeout;  // Bit 1
        logic rval_is_odd;   // Bit 0
    } fault_t;

endpackage

//--- rtl/rd_stamp_fifo.sv
`timescale 1ns/10ps

module rd_stamp_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             rst,
    input  logic             clk,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
    localparam int CW = $clog2(DEPTH + 1);                // Fill count width

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    // Wraps at DEPTH, so any depth works
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push & ~full;   // Overflow ignored
    assign do_pop  = pop & ~empty;   // Underflow ignored

    always_ff @(posedge rst) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    assign dout  = mem[rd_ptr];      // Show-ahead head
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mm_guard -f compile.f || exit 1
sim_out="$(./obj_dir/Vtb_mm_guard 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Everything OK" && exit 0 || exit 1

//--- testbench/tb_mm_guard_tests.svh
// Prints the reason and the fail line before stopping
task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_value(input string test, input string what,
                           input logic [MM_DW-1:0] expected, input logic [MM_DW-1:0] actual);
    if (actual !== expected) begin
        stop_run($sformatf("ERR %s %s expected %h actual %h", test, what, expected, actual));
    end
endtask

function automatic logic [APB_AW-1:0] win_addr(input int port, input logic [MM_AW-1:0] off);
    return {1'b0, PORT_W'(port), off};   // Window view
endfunction

function automatic logic [MM_DW-1:0] status_bit(input int port, input int kind);
    return MM_DW'(1) << (3 * port + kind);
endfunction

// One APB transfer with a setup phase and access phases until pready
task automatic apb_access(input string test, input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [MM_DW-1:0] wdata,
                          output logic [MM_DW-1:0] rdata, output logic err);
    int cycles;
    @(posedge rst);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge rst);
    penable <= 1'b1;
    cycles = 0;
    do begin
        @(posedge rst);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            stop_run($sformatf("%s: no pready after %0d cycles", test, cycles));
        end
    end while (pready !== 1'b1);
    rdata = prdata;   // Sampled in the completing cycle
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic set_mode(input int port, input logic [1:0] mode);
    @(posedge rst);
    slave_mode[port] <= mode;
endtask

// Status register holds the expected sticky flags and irq follows them
task automatic check_status(input string test);
    logic [MM_DW-1:0] st;
    logic             err;
    apb_access(test, 1'b0, STAT_ADDR, '0, st, err);
    check_value(test, "status", exp_status, st);
    check_value(test, "status pslverr", '0, MM_DW'(err));
    check_value(test, "irq", MM_DW'(exp_status != '0), MM_DW'(irq));
endtask

// Write then read back one random word with no error expected
task automatic write_read_back(input string test, input int port);
    logic [MM_AW-1:0] off;
    logic [MM_DW-1:0] data;
    logic [MM_DW-1:0] rd;
    logic             err;
    off  = MM_AW'(next_rand());
    data = next_rand();
    apb_access(test, 1'b1, win_addr(port, off), data, rd, err);
    check_value(test, "write pslverr", '0, MM_DW'(err));
    apb_access(test, 1'b0, win_addr(port, off), '0, rd, err);
    check_value(test, "read data", data, rd);
    check_value(test, "read pslverr", '0, MM_DW'(err));
endtask

task automatic test_normal_rw();
    logic [MM_AW-1:0] offs [4];
    logic [MM_DW-1:0] words [4][NP];
    logic [31:0]      r;
    logic [MM_DW-1:0] rd;
    logic             err;
    // All writes land before any read, same offset on every port
    for (int k = 0; k < 4; k++) begin
        r       = next_rand();
        offs[k] = {r[MM_AW-1:2], 2'(k)};   // Distinct low bits per offset
        for (int p = 0; p < NP; p++) begin
            words[k][p] = next_rand();
            apb_access("normal_rw", 1'b1, win_addr(p, offs[k]), words[k][p], rd, err);
            check_value("normal_rw", "write pslverr", '0, MM_DW'(err));
        end
    end
    for (int k = 0; k < 4; k++) begin
        for (int p = 0; p < NP; p++) begin
            apb_access("normal_rw", 1'b0, win_addr(p, offs[k]), '0, rd, err);
            check_value("normal_rw", "read data", words[k][p], rd);
            check_value("normal_rw", "read pslverr", '0, MM_DW'(err));
        end
    end
    check_status("normal_rw");   // No faults yet
endtask

task automatic test_busy_timeout();
    logic [MM_DW-1:0] rd;
    logic             err;
    set_mode(1, MODE_BUSY);
    apb_access("busy_timeout", 1'b1, win_addr(1, 8'h21), next_rand(), rd, err);
    check_value("busy_timeout", "write pslverr", MM_DW'(1), MM_DW'(err));
    exp_status = exp_status | status_bit(1, KIND_BUSY);
    check_status("busy_timeout");
    set_mode(1, MODE_NORMAL);
    write_read_back("busy_timeout", 1);   // Port works again
endtask

task automatic test_rval_timeout();
    logic [MM_DW-1:0] rd;
    logic             err;
    set_mode(0, MODE_NORVAL);
    apb_access("rval_timeout", 1'b0, win_addr(0, 8'h5c), '0, rd, err);
    check_value("rval_timeout", "forced data", ALL_ONES, rd);
    check_value("rval_timeout", "read pslverr", MM_DW'(1), MM_DW'(err));
    exp_status = exp_status | status_bit(0, KIND_RVAL);
    check_status("rval_timeout");
    set_mode(0, MODE_NORMAL);
    write_read_back("rval_timeout", 0);
endtask

task automatic test_odd_rval();
    logic [MM_DW-1:0] st;
    logic             err;
    int               polls;
    set_mode(1, MODE_ODD);
    for (int k = 0; k < 3; k++) begin
        write_read_back("odd_rval", 0);   // Other port unaffected
    end
    polls = 0;
    do begin
        apb_access("odd_rval", 1'b0, STAT_ADDR, '0, st, err);
        polls++;
        if (polls > 12) stop_run("odd_rval: rval_is_odd flag never set for port 1");
    end while ((st & status_bit(1, KIND_ODD)) == '0);
    set_mode(1, MODE_NORMAL);
    exp_status = exp_status | status_bit(1, KIND_ODD);
    check_status("odd_rval");
endtask

task automatic test_status_clear();
    logic [MM_DW-1:0] rd;
    logic             err;
    apb_access("status_clear", 1'b1, STAT_ADDR, status_bit(1, KIND_BUSY), rd, err);
    exp_status = exp_status & ~status_bit(1, KIND_BUSY);   // Only that bit goes
    check_status("status_clear");
    apb_access("status_clear", 1'b1, STAT_ADDR, ALL_ONES, rd, err);
    exp_status = '0;
    check_status("status_clear");   // irq low again
endtask

//--- testbench/tb_mm_guard.sv
`timescale 1ns/10ps

module tb_mm_guard import mmg_pkg::*; ();

    localparam int NP         = 2;
    localparam int HALF_CYCLE = 50;    // 100 ns clock period
    localparam int WAIT_LIMIT = 40;    // Max cycles for any single wait

    // Slave model modes
    localparam logic [1:0] MODE_NORMAL = 2'd0;
    localparam logic [1:0] MODE_BUSY   = 2'd1;  // Busy stuck high
    localparam logic [1:0] MODE_NORVAL = 2'd2;  // Reads accepted, never answered
    localparam logic [1:0] MODE_ODD    = 2'd3;  // Unsolicited rvals

    // Position of each fault kind inside a port's 3-bit status field
    localparam int KIND_ODD  = 0;
    localparam int KIND_RVAL = 1;
    localparam int KIND_BUSY = 2;

    localparam logic [APB_AW-1:0] STAT_ADDR = 12'h800;  // Select bit set
    localparam logic [MM_DW-1:0]  ALL_ONES  = 32'hffff_ffff;

    logic              rst;       // Clock
    logic              clk;       // Reset, active high
    logic              psel;
    logic              penable;
    logic              pwrite;
    apb_addr_u         paddr;
    logic [MM_DW-1:0]  pwdata;
    logic              pready;
    logic [MM_DW-1:0]  prdata;
    logic              pslverr;
    logic              irq;
    mm_req_t           m_req [NP];
    mm_rsp_t           m_rsp [NP];
    logic [1:0]        slave_mode [NP];
    logic [31:0]       rng_state;
    logic [MM_DW-1:0]  exp_status;   // Sticky flags expected so far

    mm_guard_top #(
        .NPORTS      (NP),
        .MAXPENDRD   (4),
        .BUSYTIMEOUT (8),
        .RVALTIMEOUT (8)
    ) dut (
        .rst     (rst),
        .clk     (clk),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .m_req   (m_req),
        .m_rsp   (m_rsp),
        .irq     (irq)
    );

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Power-up contents, unique per port and address
    function automatic logic [MM_DW-1:0] fill_word(input int port, input int addr);
        return {8'(port) ^ 8'hc3, 8'(addr), ~8'(addr), 8'(addr) ^ 8'h96};
    endfunction

    // Slave models, read latency 2
    for (genvar p = 0; p < NP; p++) begin : g_slave
        logic [MM_DW-1:0] mem [256];
        logic             rd_pend = 1'b0;   // Read accepted last cycle
        logic [MM_AW-1:0] rd_addr = '0;
        logic             rval_q  = 1'b0;
        logic [MM_DW-1:0] rdat_q  = '0;
        logic [3:0]       tick    = '0;     // Paces the odd rvals
        logic             accept;

        assign accept = (m_req[p].wreq | m_req[p].rreq) & (slave_mode[p] != MODE_BUSY);

        always @(posedge rst) begin
            if (clk) begin
                for (int a = 0; a < 256; a++) begin
                    mem[a] <= fill_word(p, a);
                end
                rd_pend <= 1'b0;
                rval_q  <= 1'b0;
                tick    <= '0;
            end else begin
                tick <= tick + 4'd1;
                if (accept & m_req[p].wreq) mem[m_req[p].addr] <= m_req[p].wdat;
                rd_pend <= accept & m_req[p].rreq;
                rd_addr <= m_req[p].addr;
                rdat_q  <= mem[rd_addr];
                rval_q  <= (rd_pend & (slave_mode[p] != MODE_NORVAL))
                         | ((slave_mode[p] == MODE_ODD) & (tick == 4'd0) & ~rd_pend);
            end
        end

        assign m_rsp[p] = '{rdat: rdat_q, rval: rval_q, busy: slave_mode[p] == MODE_BUSY};
    end

    `include "tb_mm_guard_tests.svh"

    initial begin
        rst = 1'b0;
        forever #HALF_CYCLE rst = ~rst;
    end

    initial begin
        clk           = 1'b1;   // Reset asserted from time 0
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        slave_mode[0] = MODE_NORMAL;
        slave_mode[1] = MODE_NORMAL;
        rng_state     = 32'hac86c514;
        exp_status    = '0;
        repeat (4) @(posedge rst);
        clk <= 1'b0;
        test_normal_rw();
        test_busy_timeout();
        test_rval_timeout();
        test_odd_rval();
        test_status_clear();
        $display("Everything OK");
        $finish;
    end

endmodule
